// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_bev -f verilog.f -o tb_bev_sim
	./obj_dir/tb_bev_sim | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

// File: logic/bev_ctrl.sv
`include "bev_params.svh"

module bev_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    order_if.consumer      ord,
    box_if.requester       bx,
    input  bev_pkg::need_t need,
    output logic           out_valid,
    output bev_pkg::err_t  err_msg,
    output logic           complete
);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_check,
        st_write,
        st_respond
    } state_t;

    state_t                     state;
    bev_pkg::box_word_t         box_q;
    bev_pkg::box_word_t         box_new;
    bev_pkg::err_t              err_q;
    bev_pkg::err_t              verdict;
    logic [`BEV_REC_DATE_W-1:0] ord_month;
    logic [`BEV_REC_DATE_W-1:0] ord_day;
    logic                       expired;
    logic                       short_ing;
    logic                       is_make;
    logic                       mem_order;

    assign is_make   = (ord.action == bev_pkg::make_drink);
    // supply and unknown actions skip the memory
    assign mem_order = is_make || (ord.action == bev_pkg::check_date);

    // ====================
    // checks
    // ====================

    // order date widened to the record field
    assign ord_month = {{(`BEV_REC_DATE_W - `BEV_MON_W){1'b0}}, ord.month};
    assign ord_day   = {{(`BEV_REC_DATE_W - `BEV_DAY_W){1'b0}}, ord.day};

    assign expired = (ord_month > box_q.fields.month) ||
                     ((ord_month == box_q.fields.month) && (ord_day > box_q.fields.day));

    // any ingredient short fails the whole drink
    assign short_ing = (need.black > box_q.fields.black) ||
                       (need.green > box_q.fields.green) ||
                       (need.milk  > box_q.fields.milk)  ||
                       (need.pine  > box_q.fields.pine);

    // expiry wins over a shortage
    always_comb begin
        if (expired) begin
            verdict = bev_pkg::no_exp;
        end else if (is_make && short_ing) begin
            verdict = bev_pkg::no_ing;
        end else begin
            verdict = bev_pkg::no_err;
        end
    end

    // write-back record keeps the date as read
    always_comb begin
        box_new              = box_q;
        box_new.fields.black = box_q.fields.black - need.black;
        box_new.fields.green = box_q.fields.green - need.green;
        box_new.fields.milk  = box_q.fields.milk - need.milk;
        box_new.fields.pine  = box_q.fields.pine - need.pine;
    end

    // held for the whole access
    assign bx.addr  = ord.box_no;
    assign bx.write = (state == st_write);
    assign bx.wdata = box_new;

    // ====================
    // order FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            bx.req <= 1'b0;
            err_q  <= bev_pkg::no_err;
        end else begin
            bx.req <= 1'b0;
            case (state)
                st_idle: begin
                    if (ord.ready && mem_order) begin
                        state  <= st_read;
                        bx.req <= 1'b1;
                    end else if (ord.ready) begin
                        state <= st_respond;
                        err_q <= bev_pkg::no_err;
                    end
                end
                st_read: begin
                    if (bx.done) begin
                        state <= st_check;
                    end
                end
                // pass on make drink goes to write-back
                st_check: begin
                    err_q <= verdict;
                    if (is_make && (verdict == bev_pkg::no_err)) begin
                        state  <= st_write;
                        bx.req <= 1'b1;
                    end else begin
                        state <= st_respond;
                    end
                end
                st_write: begin
                    if (bx.done) begin
                        state <= st_respond;
                    end
                end
                st_respond: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // record from the read response
    always_ff @(posedge clk) begin
        if ((state == st_read) && bx.done) begin
            box_q <= bx.rdata;
        end
    end

    // ====================
    // results
    // ====================
    assign out_valid = (state == st_respond);
    assign err_msg   = out_valid ? err_q : bev_pkg::no_err;
    assign complete  = out_valid && (err_q == bev_pkg::no_err);

    // next order only once the last result is out
    a_order_idle: assert property (@(posedge clk) disable iff (!rst_n)
        ord.ready |-> (state == st_idle));

endmodule

// File: logic/bev_ifs.sv
`include "bev_params.svh"

// ====================
// held order
// ====================
interface order_if;
    // one-cycle pulse once the box number is in
    logic                   ready;
    // fields hold until the next action arrives
    bev_pkg::action_t       action;
    bev_pkg::drink_t        drink;
    bev_pkg::size_t         size;
    logic [`BEV_MON_W-1:0]  month;
    logic [`BEV_DAY_W-1:0]  day;
    logic [`BEV_ADDR_W-1:0] box_no;

    modport producer (output ready, action, drink, size, month, day, box_no);
    modport consumer (input ready, action, drink, size, month, day, box_no);
endinterface

// ====================
// box access
// ====================
interface box_if;
    // single outstanding access
    logic                   req;
    logic                   write;
    logic [`BEV_ADDR_W-1:0] addr;
    bev_pkg::box_word_t     wdata;
    // done pulses with the memory response
    logic                   done;
    bev_pkg::box_word_t     rdata;

    modport requester (output req, write, addr, wdata, input done, rdata);
    modport responder (input req, write, addr, wdata, output done, rdata);
endinterface

// File: logic/bev_params.svh
`ifndef BEV_PARAMS_SVH
`define BEV_PARAMS_SVH

// ====================
// order bus
// ====================

// shared input bus, sized for the date field
`define BEV_IN_W 9
// box number, doubles as the memory address
`define BEV_ADDR_W 8
// date on the bus: month sits above day
`define BEV_MON_W 4
`define BEV_DAY_W 5
`define BEV_IN_MON_LSB 5

// ====================
// box record
// ====================

// from msb: black, green, month, milk, pineapple, day
`define BEV_BOX_W 64
`define BEV_VOL_W 12
`define BEV_REC_DATE_W 8

// total cup volume per size
`define BEV_CUP_L 12'd960
`define BEV_CUP_M 12'd720
`define BEV_CUP_S 12'd480

`endif

// File: logic/bev_pkg.sv
`include "bev_params.svh"

package bev_pkg;

    // supply is decoded but answered without any memory access
    typedef enum logic [1:0] {
        make_drink = 2'd0,
        supply     = 2'd1,
        check_date = 2'd2
    } action_t;

    typedef enum logic [2:0] {
        black_tea,
        milk_tea,
        extra_milk_tea,
        green_tea,
        green_milk_tea,
        pineapple_juice,
        super_pineapple_tea,
        super_pineapple_milk_tea
    } drink_t;

    // encoding 2 is unused
    typedef enum logic [1:0] {
        size_l = 2'd0,
        size_m = 2'd1,
        size_s = 2'd3
    } size_t;

    typedef enum logic [1:0] {
        no_err = 2'd0,
        no_exp = 2'd1,
        no_ing = 2'd2
    } err_t;

    // field view of one box, top bit first
    typedef struct packed {
        logic [`BEV_VOL_W-1:0]      black;
        logic [`BEV_VOL_W-1:0]      green;
        logic [`BEV_REC_DATE_W-1:0] month;
        logic [`BEV_VOL_W-1:0]      milk;
        logic [`BEV_VOL_W-1:0]      pine;
        logic [`BEV_REC_DATE_W-1:0] day;
    } box_fields_t;

    // memory side moves raw, controller decodes fields
    typedef union packed {
        logic [`BEV_BOX_W-1:0] raw;
        box_fields_t           fields;
    } box_word_t;

    // required volume per ingredient
    typedef struct packed {
        logic [`BEV_VOL_W-1:0] black;
        logic [`BEV_VOL_W-1:0] green;
        logic [`BEV_VOL_W-1:0] milk;
        logic [`BEV_VOL_W-1:0] pine;
    } need_t;

endpackage

// File: logic/bev_top.sv
`include "bev_params.svh"

module bev_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // order side
    input  logic [`BEV_IN_W-1:0]   in_data,
    input  logic                   act_valid,
    input  logic                   type_valid,
    input  logic                   size_valid,
    input  logic                   date_valid,
    input  logic                   box_no_valid,
    // box memory
    output logic [`BEV_ADDR_W-1:0] c_addr,
    output logic                   c_r_wb,
    output logic                   c_in_valid,
    output logic [`BEV_BOX_W-1:0]  c_data_w,
    input  logic                   c_out_valid,
    input  logic [`BEV_BOX_W-1:0]  c_data_r,
    // results
    output logic                   out_valid,
    output bev_pkg::err_t          err_msg,
    output logic                   complete
);

    order_if        ord_bus ();
    box_if          box_bus ();
    bev_pkg::need_t need;

    // ====================
    // order path
    // ====================
    order_capture u_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_data      (in_data),
        .act_valid    (act_valid),
        .type_valid   (type_valid),
        .size_valid   (size_valid),
        .date_valid   (date_valid),
        .box_no_valid (box_no_valid),
        .ord          (ord_bus)
    );

    // fed straight from the held order
    recipe_table u_recipe (
        .drink (ord_bus.drink),
        .size  (ord_bus.size),
        .need  (need)
    );

    bev_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .ord       (ord_bus),
        .bx        (box_bus),
        .need      (need),
        .out_valid (out_valid),
        .err_msg   (err_msg),
        .complete  (complete)
    );

    // ====================
    // memory path
    // ====================
    box_link u_link (
        .clk         (clk),
        .rst_n       (rst_n),
        .bx          (box_bus),
        .c_addr      (c_addr),
        .c_r_wb      (c_r_wb),
        .c_in_valid  (c_in_valid),
        .c_data_w    (c_data_w),
        .c_out_valid (c_out_valid),
        .c_data_r    (c_data_r)
    );

endmodule

// File: logic/box_link.sv
`include "bev_params.svh"

module box_link (
    input  logic                   clk,
    input  logic                   rst_n,
    box_if.responder               bx,
    output logic [`BEV_ADDR_W-1:0] c_addr,
    output logic                   c_r_wb,
    output logic                   c_in_valid,
    output logic [`BEV_BOX_W-1:0]  c_data_w,
    input  logic                   c_out_valid,
    input  logic [`BEV_BOX_W-1:0]  c_data_r
);

    // high from request until the memory answers
    logic pending;

    // ====================
    // request side
    // ====================

    // c_in_valid trails req by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_in_valid <= 1'b0;
            pending    <= 1'b0;
        end else begin
            c_in_valid <= bx.req;
            if (bx.req) begin
                pending <= 1'b1;
            end else if (c_out_valid) begin
                pending <= 1'b0;
            end
        end
    end

    // address and data ride with c_in_valid
    always_ff @(posedge clk) begin
        if (bx.req) begin
            c_addr   <= bx.addr;
            // memory side: 1 = read, 0 = write
            c_r_wb   <= !bx.write;
            c_data_w <= bx.wdata.raw;
        end
    end

    // ====================
    // response side
    // ====================

    // stray responses never reach the controller
    assign bx.done  = c_out_valid && pending;
    assign bx.rdata = bev_pkg::box_word_t'(c_data_r);

    // the memory only answers what was asked
    a_no_stray_resp: assert property (@(posedge clk) disable iff (!rst_n)
        c_out_valid |-> pending);

    // controller keeps one access in flight
    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        bx.req |-> !pending);

endmodule

// File: logic/order_capture.sv
`include "bev_params.svh"

module order_capture (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`BEV_IN_W-1:0] in_data,
    input  logic                 act_valid,
    input  logic                 type_valid,
    input  logic                 size_valid,
    input  logic                 date_valid,
    input  logic                 box_no_valid,
    order_if.producer            ord
);

    // box number always comes last, so it closes the order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ord.ready <= 1'b0;
        end else begin
            ord.ready <= box_no_valid;
        end
    end

    // ====================
    // field latches
    // ====================

    // each field loads on its own valid only
    always_ff @(posedge clk) begin
        if (act_valid) begin
            ord.action <= bev_pkg::action_t'(in_data[1:0]);
        end
        if (type_valid) begin
            ord.drink <= bev_pkg::drink_t'(in_data[2:0]);
        end
        if (size_valid) begin
            ord.size <= bev_pkg::size_t'(in_data[1:0]);
        end
        // month above day on the bus
        if (date_valid) begin
            ord.month <= in_data[`BEV_IN_MON_LSB +: `BEV_MON_W];
            ord.day   <= in_data[`BEV_DAY_W-1:0];
        end
        if (box_no_valid) begin
            ord.box_no <= in_data[`BEV_ADDR_W-1:0];
        end
    end

    // the bus carries one field per cycle
    a_one_valid: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({act_valid, type_valid, size_valid, date_valid, box_no_valid}));

endmodule

// File: logic/recipe_table.sv
`include "bev_params.svh"

module recipe_table (
    input  bev_pkg::drink_t drink,
    input  bev_pkg::size_t  size,
    output bev_pkg::need_t  need
);

    logic [`BEV_VOL_W-1:0] cup;
    logic [`BEV_VOL_W-1:0] half;
    logic [`BEV_VOL_W-1:0] quarter;

    // cup volume for the size
    always_comb begin
        case (size)
            bev_pkg::size_l: cup = `BEV_CUP_L;
            bev_pkg::size_m: cup = `BEV_CUP_M;
            bev_pkg::size_s: cup = `BEV_CUP_S;
            default:         cup = '0;
        endcase
    end

    // all cup sizes divide by four exactly
    assign half    = cup >> 1;
    assign quarter = cup >> 2;

    // ====================
    // recipe fractions
    // ====================
    always_comb begin
        need = '0;
        case (drink)
            bev_pkg::black_tea: begin
                need.black = cup;
            end
            // three quarters tea, one quarter milk
            bev_pkg::milk_tea: begin
                need.black = half + quarter;
                need.milk  = quarter;
            end
            bev_pkg::extra_milk_tea: begin
                need.black = half;
                need.milk  = half;
            end
            bev_pkg::green_tea: begin
                need.green = cup;
            end
            bev_pkg::green_milk_tea: begin
                need.green = half;
                need.milk  = half;
            end
            bev_pkg::pineapple_juice: begin
                need.pine = cup;
            end
            bev_pkg::super_pineapple_tea: begin
                need.black = half;
                need.pine  = half;
            end
            bev_pkg::super_pineapple_milk_tea: begin
                need.black = half;
                need.pine  = quarter;
                need.milk  = quarter;
            end
            default: begin
                need = '0;
            end
        endcase
    end

    // size 2 has no cup; skip the check until a size is latched
    always_comb begin
        if (!$isunknown(size)) begin
            a_size_legal: assert (size != 2'd2);
        end
    end

endmodule

// File: testbench/box_memory_model.sv
`include "bev_params.svh"

module box_memory_model (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`BEV_ADDR_W-1:0] c_addr,
    input  logic                   c_r_wb,
    input  logic                   c_in_valid,
    input  logic [`BEV_BOX_W-1:0]  c_data_w,
    output logic                   c_out_valid,
    output logic [`BEV_BOX_W-1:0]  c_data_r,
    // preload port, driven by the testbench
    input  logic                   load_en,
    input  logic [`BEV_ADDR_W-1:0] load_addr,
    input  logic [`BEV_BOX_W-1:0]  load_data
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`BEV_BOX_W-1:0]  mem [0:255];
    integer                 seed;
    logic [31:0]            draw;
    logic                   busy;
    logic [1:0]             wait_cnt;
    logic [`BEV_ADDR_W-1:0] addr_q;

    // fill pattern built from every address bit
    initial begin
        seed = 32'h364b;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8{8'(i) ^ 8'h5a}} ^ {56'd0, 8'(i)};
        end
    end

    // writes land when the request is taken
    always @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (c_in_valid && !c_r_wb) begin
            mem[c_addr] <= c_data_w;
        end
    end

    // ====================
    // response timing
    // ====================

    // one answer per request, 1 to 4 cycles later
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_out_valid <= 1'b0;
            c_data_r    <= '0;
            busy        <= 1'b0;
            wait_cnt    <= 2'd0;
            addr_q      <= '0;
        end else begin
            c_out_valid <= 1'b0;
            if (c_in_valid) begin
                draw = $random(seed);
                wait_cnt <= draw[1:0];
                addr_q   <= c_addr;
                busy     <= 1'b1;
            end else if (busy) begin
                if (wait_cnt == 2'd0) begin
                    c_out_valid <= 1'b1;
                    c_data_r    <= mem[addr_q];
                    busy        <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

// File: testbench/tb_bev.sv
`include "bev_params.svh"

module tb_bev;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;

    logic                   clk;
    logic                   rst_n;
    logic [`BEV_IN_W-1:0]   in_data;
    logic                   act_valid;
    logic                   type_valid;
    logic                   size_valid;
    logic                   date_valid;
    logic                   box_no_valid;
    logic [`BEV_ADDR_W-1:0] c_addr;
    logic                   c_r_wb;
    logic                   c_in_valid;
    logic [`BEV_BOX_W-1:0]  c_data_w;
    logic                   c_out_valid;
    logic [`BEV_BOX_W-1:0]  c_data_r;
    logic                   out_valid;
    bev_pkg::err_t          err_msg;
    logic                   complete;
    logic                   load_en;
    logic [`BEV_ADDR_W-1:0] load_addr;
    logic [`BEV_BOX_W-1:0]  load_data;

    int            errors;
    int            tests;
    int            test_start;
    bev_pkg::err_t got_err;
    logic          got_complete;

    bev_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_data      (in_data),
        .act_valid    (act_valid),
        .type_valid   (type_valid),
        .size_valid   (size_valid),
        .date_valid   (date_valid),
        .box_no_valid (box_no_valid),
        .c_addr       (c_addr),
        .c_r_wb       (c_r_wb),
        .c_in_valid   (c_in_valid),
        .c_data_w     (c_data_w),
        .c_out_valid  (c_out_valid),
        .c_data_r     (c_data_r),
        .out_valid    (out_valid),
        .err_msg      (err_msg),
        .complete     (complete)
    );

    box_memory_model mem_model (
        .clk         (clk),
        .rst_n       (rst_n),
        .c_addr      (c_addr),
        .c_r_wb      (c_r_wb),
        .c_in_valid  (c_in_valid),
        .c_data_w    (c_data_w),
        .c_out_valid (c_out_valid),
        .c_data_r    (c_data_r),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ====================
    // compare tasks
    // ====================
    task automatic check_err(input bev_pkg::err_t exp, input bev_pkg::err_t got,
                             input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s err_msg expected %s got %s",
                     $time, what, exp.name(), got.name());
            errors++;
        end
    endtask

    task automatic check_box(input bev_pkg::box_word_t exp, input bev_pkg::box_word_t got,
                             input string what);
        if (got.raw !== exp.raw) begin
            $display("Mismatch at %0t: %s record expected %h got %h",
                     $time, what, exp.raw, got.raw);
            errors++;
        end
    endtask

    task automatic check_bit(input logic exp, input logic got, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == test_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    // ====================
    // model of the rules
    // ====================
    function automatic bev_pkg::box_word_t make_box(
        input logic [`BEV_VOL_W-1:0] black, input logic [`BEV_VOL_W-1:0] green,
        input logic [7:0] month, input logic [`BEV_VOL_W-1:0] milk,
        input logic [`BEV_VOL_W-1:0] pine, input logic [7:0] day);
        bev_pkg::box_word_t b;
        b.fields.black = black;
        b.fields.green = green;
        b.fields.month = month;
        b.fields.milk  = milk;
        b.fields.pine  = pine;
        b.fields.day   = day;
        return b;
    endfunction

    // quarters of the cup per ingredient: black, green, milk, pineapple
    function automatic bev_pkg::need_t expected_need(input bev_pkg::drink_t drink,
                                                     input bev_pkg::size_t size);
        int             cup;
        logic [15:0]    q;
        bev_pkg::need_t n;
        cup = (size == bev_pkg::size_l) ? 960 : (size == bev_pkg::size_m) ? 720 : 480;
        case (drink)
            bev_pkg::black_tea:                q = 16'h4000;
            bev_pkg::milk_tea:                 q = 16'h3010;
            bev_pkg::extra_milk_tea:           q = 16'h2020;
            bev_pkg::green_tea:                q = 16'h0400;
            bev_pkg::green_milk_tea:           q = 16'h0220;
            bev_pkg::pineapple_juice:          q = 16'h0004;
            bev_pkg::super_pineapple_tea:      q = 16'h2002;
            bev_pkg::super_pineapple_milk_tea: q = 16'h2011;
            default:                           q = 16'h0000;
        endcase
        n.black = 12'((cup * int'(q[15:12])) / 4);
        n.green = 12'((cup * int'(q[11:8])) / 4);
        n.milk  = 12'((cup * int'(q[7:4])) / 4);
        n.pine  = 12'((cup * int'(q[3:0])) / 4);
        return n;
    endfunction

    // poured volumes leave the box, date stays
    function automatic bev_pkg::box_word_t remove_need(input bev_pkg::box_word_t b,
                                                       input bev_pkg::need_t n);
        return make_box(b.fields.black - n.black, b.fields.green - n.green, b.fields.month,
                        b.fields.milk - n.milk, b.fields.pine - n.pine, b.fields.day);
    endfunction

    // ====================
    // drivers
    // ====================
    task automatic load_box(input logic [`BEV_ADDR_W-1:0] addr, input bev_pkg::box_word_t b);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = addr;
        load_data = b.raw;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // sel order: act, type, size, date, box number
    task automatic pulse_field(input logic [4:0] sel, input logic [`BEV_IN_W-1:0] value);
        @(negedge clk);
        in_data = value;
        {act_valid, type_valid, size_valid, date_valid, box_no_valid} = sel;
        @(negedge clk);
        {act_valid, type_valid, size_valid, date_valid, box_no_valid} = 5'b0;
        in_data = '0;
    endtask

    task automatic wait_result(output logic seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (out_valid) begin
                seen         = 1'b1;
                got_err      = err_msg;
                got_complete = complete;
            end
        end
    endtask

    task automatic run_order(input bev_pkg::action_t act, input bev_pkg::drink_t drink,
                             input bev_pkg::size_t size, input logic [3:0] month,
                             input logic [4:0] day, input logic [`BEV_ADDR_W-1:0] box);
        logic seen;
        pulse_field(5'b10000, {7'd0, act});
        if (act == bev_pkg::make_drink) begin
            pulse_field(5'b01000, {6'd0, drink});
            pulse_field(5'b00100, {7'd0, size});
        end
        pulse_field(5'b00010, {month, day});
        pulse_field(5'b00001, {1'b0, box});
        wait_result(seen);
        if (!seen) begin
            $display("Timeout at %0t: no out_valid for the order on box %0d", $time, box);
            errors++;
        end
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic test_reset_idle();
        repeat (12) begin
            @(negedge clk);
            check_bit(1'b0, out_valid, "idle out_valid");
            check_bit(1'b0, complete, "idle complete");
            check_bit(1'b0, c_in_valid, "idle c_in_valid");
            check_err(bev_pkg::no_err, err_msg, "idle");
        end
        report_test("reset_idle");
    endtask

    task automatic test_check_date();
        bev_pkg::box_word_t b;
        b = make_box(12'd800, 12'd700, 8'd6, 12'd600, 12'd500, 8'd15);
        load_box(8'd8, b);
        // same day is still good
        run_order(bev_pkg::check_date, bev_pkg::black_tea, bev_pkg::size_l, 4'd6, 5'd15, 8'd8);
        check_err(bev_pkg::no_err, got_err, "date same day");
        check_bit(1'b1, got_complete, "date same day complete");
        run_order(bev_pkg::check_date, bev_pkg::black_tea, bev_pkg::size_l, 4'd6, 5'd16, 8'd8);
        check_err(bev_pkg::no_exp, got_err, "date later day");
        check_bit(1'b0, got_complete, "date later day complete");
        run_order(bev_pkg::check_date, bev_pkg::black_tea, bev_pkg::size_l, 4'd7, 5'd1, 8'd8);
        check_err(bev_pkg::no_exp, got_err, "date later month");
        check_box(b, bev_pkg::box_word_t'(mem_model.mem[8]), "date");
        report_test("check_date");
    endtask

    task automatic test_make_all();
        bev_pkg::size_t         sizes [0:2];
        bev_pkg::box_word_t     b;
        bev_pkg::drink_t        drink;
        logic [`BEV_ADDR_W-1:0] addr;
        sizes[0] = bev_pkg::size_l;
        sizes[1] = bev_pkg::size_m;
        sizes[2] = bev_pkg::size_s;
        for (int d = 0; d < 8; d++) begin
            for (int k = 0; k < 3; k++) begin
                drink = bev_pkg::drink_t'(d[2:0]);
                addr  = 8'(16 + d * 3 + k);
                // stock varies with the box number
                b = make_box(12'd3000 - 12'(addr), 12'd2000 + 12'(addr), 8'd11,
                             12'd1500, 12'd1200 + 12'(addr), 8'd20);
                load_box(addr, b);
                run_order(bev_pkg::make_drink, drink, sizes[k], 4'd3, 5'd4, addr);
                check_err(bev_pkg::no_err, got_err, drink.name());
                check_bit(1'b1, got_complete, drink.name());
                check_box(remove_need(b, expected_need(drink, sizes[k])),
                          bev_pkg::box_word_t'(mem_model.mem[addr]), drink.name());
            end
        end
        report_test("make_all");
    endtask

    task automatic test_short_ingredient();
        bev_pkg::need_t     n;
        bev_pkg::box_word_t b;
        // milk one unit short
        n = expected_need(bev_pkg::milk_tea, bev_pkg::size_m);
        b = make_box(n.black, 12'd0, 8'd9, n.milk - 12'd1, 12'd0, 8'd1);
        load_box(8'd100, b);
        run_order(bev_pkg::make_drink, bev_pkg::milk_tea, bev_pkg::size_m, 4'd1, 5'd1, 8'd100);
        check_err(bev_pkg::no_ing, got_err, "short milk");
        check_bit(1'b0, got_complete, "short milk complete");
        check_box(b, bev_pkg::box_word_t'(mem_model.mem[100]), "short milk");
        n = expected_need(bev_pkg::pineapple_juice, bev_pkg::size_l);
        b = make_box(12'd4095, 12'd4095, 8'd9, 12'd4095, n.pine - 12'd1, 8'd1);
        load_box(8'd101, b);
        run_order(bev_pkg::make_drink, bev_pkg::pineapple_juice, bev_pkg::size_l,
                  4'd1, 5'd1, 8'd101);
        check_err(bev_pkg::no_ing, got_err, "short pineapple");
        check_box(b, bev_pkg::box_word_t'(mem_model.mem[101]), "short pineapple");
        report_test("short_ingredient");
    endtask

    // empty and expired, expiry reported first
    task automatic test_expired_short();
        bev_pkg::box_word_t b;
        b = make_box(12'd0, 12'd0, 8'd2, 12'd0, 12'd0, 8'd10);
        load_box(8'd120, b);
        run_order(bev_pkg::make_drink, bev_pkg::black_tea, bev_pkg::size_l, 4'd3, 5'd1, 8'd120);
        check_err(bev_pkg::no_exp, got_err, "expired short");
        check_bit(1'b0, got_complete, "expired short complete");
        check_box(b, bev_pkg::box_word_t'(mem_model.mem[120]), "expired short");
        report_test("expired_short");
    endtask

    initial begin
        errors       = 0;
        tests        = 0;
        test_start   = 0;
        got_err      = bev_pkg::no_err;
        got_complete = 1'b0;
        rst_n        = 1'b0;
        in_data      = '0;
        {act_valid, type_valid, size_valid, date_valid, box_no_valid} = 5'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        test_reset_idle();
        test_check_date();
        test_make_all();
        test_short_ingredient();
        test_expired_short();
        $display("summary: %0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/bev_pkg.sv
logic/bev_ifs.sv
logic/order_capture.sv
logic/recipe_table.sv
logic/box_link.sv
logic/bev_ctrl.sv
logic/bev_top.sv
testbench/box_memory_model.sv
testbench/tb_bev.sv
